// File: project.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/reg_table.sv
hdl/rob_alloc.sv
hdl/rename_stage.sv
dv/tb_clkgen.sv
dv/rename_chk.sv
dv/rename_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module rename_tb \
    -o sim_rename > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_rename > sim.log 2>&1 || true
cat sim.log

grep -qx "TEST PASS" sim.log && exit 0 || exit 1

// File: dv/rename_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module rename_tb;

    import rename_pkg::*;

    typedef struct packed {
        logic [1:0]     slot_valid;
        rob_id_t [3:0]  src_robid;
        xlen_t [3:0]    src_data;
        logic [3:0]     src_ready;
        rob_id_t [1:0]  dst_robid;
        logic [1:0]     dst_check;
        xlen_t          pc;
    } bundle_t;

    typedef struct packed {
        rob_id_t robid;
        logic    check;
        arf_id_t rd;
    } inflight_t;

    logic clk;
    logic rst_i;
    logic d_valid_i;
    logic [1:0] d_slot_valid_i;
    arf_id_t [3:0] d_rs_id_i;
    arf_id_t [1:0] d_rd_id_i;
    logic [1:0] d_wreg_i;
    xlen_t d_pc_i;
    logic d_ready_o;
    logic [1:0] p_slot_valid_o;
    rob_id_t [3:0] p_src_robid_o;
    xlen_t [3:0] p_src_data_o;
    logic [3:0] p_src_ready_o;
    rob_id_t [1:0] p_dst_robid_o;
    logic [1:0] p_dst_check_o;
    xlen_t p_pc_o;
    logic p_ready_i;
    logic c_flush_i;
    logic [1:0] c_retire_i;
    logic [1:0] c_wvalid_i;
    logic [1:0] c_wcheck_i;
    arf_id_t [1:0] c_arfid_i;
    rob_id_t [1:0] c_robid_i;
    xlen_t [1:0] c_data_i;

    // model state
    rat_entry_t spec_m [`RN_ARF_DEPTH];
    rat_entry_t commit_m [`RN_ARF_DEPTH];
    xlen_t arf_m [`RN_ARF_DEPTH];
    rob_id_t ptr0_m;
    int occ_m;
    bit avail_m;
    inflight_t inflight_q [$];

    bundle_t exp_bundle;
    bundle_t cmp_exp;
    bundle_t held;
    bit launch;
    int checks;
    int errors;
    int timeouts;
    int tests;
    int tests_failed;
    int start_errs;
    int start_touts;
    int k;

    tb_clkgen clkgen (.clk_o(clk), .rst_o(rst_i));

    rename_stage uut (.*);

    bind rename_stage rename_chk u_chk (
        .clk          (clk),
        .rst_i        (rst_i),
        .flush_i      (c_flush_i),
        .p_ready_i    (p_ready_i),
        .d_ready_i    (d_ready_o),
        .slot_valid_i (p_slot_valid_o),
        .src_ready_i  (p_src_ready_o),
        .pc_i         (p_pc_o)
    );

    task automatic check_val(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("timed out waiting for %s", what);
    endtask

    // expected bundle from the rename rules and the model state
    function automatic bundle_t expect_bundle(input bit acc);
        bundle_t b;
        logic [1:0] iss;
        iss = d_slot_valid_i & {2{acc}};
        b.slot_valid = iss;
        for (int j = 0; j < 4; j++) begin
            b.src_robid[j] = spec_m[d_rs_id_i[j]].robid;
            if (d_rs_id_i[j] == 0) begin
                b.src_ready[j] = 1'b1;
                b.src_data[j] = '0;
            end else begin
                b.src_ready[j] = (spec_m[d_rs_id_i[j]] == commit_m[d_rs_id_i[j]]);
                b.src_data[j] = arf_m[d_rs_id_i[j]];
            end
        end
        if (iss == 2'b10) begin
            b.dst_robid[1] = ptr0_m;
            b.dst_robid[0] = ptr0_m + rob_id_t'(1);
        end else begin
            b.dst_robid[0] = ptr0_m;
            b.dst_robid[1] = ptr0_m + rob_id_t'(1);
        end
        for (int i = 0; i < 2; i++) begin
            b.dst_check[i] = ~commit_m[d_rd_id_i[i]].check;
        end
        b.pc = d_pc_i;
        return b;
    endfunction

    task automatic compare_bundle(input bundle_t e);
        check_val("p_slot_valid_o", 64'(p_slot_valid_o), 64'(e.slot_valid));
        for (int j = 0; j < 4; j++) begin
            check_val($sformatf("p_src_robid_o[%0d]", j), 64'(p_src_robid_o[j]),
                      64'(e.src_robid[j]));
            check_val($sformatf("p_src_data_o[%0d]", j), 64'(p_src_data_o[j]),
                      64'(e.src_data[j]));
            check_val($sformatf("p_src_ready_o[%0d]", j), 64'(p_src_ready_o[j]),
                      64'(e.src_ready[j]));
        end
        check_val("p_dst_robid_o", 64'(p_dst_robid_o), 64'(e.dst_robid));
        check_val("p_dst_check_o", 64'(p_dst_check_o), 64'(e.dst_check));
        check_val("p_pc_o", 64'(p_pc_o), 64'(e.pc));
    endtask

    task automatic clear_model();
        for (int i = 0; i < `RN_ARF_DEPTH; i++) begin
            spec_m[i] = '0;
            commit_m[i] = '0;
        end
        ptr0_m = '0;
        occ_m = 0;
        avail_m = 1'b1;
        inflight_q.delete();
    endtask

    task automatic idle_inputs();
        d_valid_i = 1'b0;
        d_slot_valid_i = '0;
        d_rs_id_i = '0;
        d_rd_id_i = '0;
        d_wreg_i = '0;
        d_pc_i = '0;
        p_ready_i = 1'b1;
        c_flush_i = 1'b0;
        c_retire_i = '0;
        c_wvalid_i = '0;
        c_wcheck_i = '0;
        c_arfid_i = '0;
        c_robid_i = '0;
        c_data_i = '0;
    endtask

    function automatic logic [19:0] random_rs();
        return {5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)),
                5'($urandom_range(0, 31)), 5'($urandom_range(0, 31))};
    endfunction

    task automatic drive_bundle(input logic [1:0] sv, input logic [19:0] rs,
                                input logic [9:0] rd);
        d_valid_i = 1'b1;
        d_slot_valid_i = sv;
        d_rs_id_i = rs;
        d_rd_id_i = rd;
        d_wreg_i = 2'b11;
        d_pc_i = $urandom;
    endtask

    task automatic drive_retire(input int slot, input xlen_t data);
        inflight_t f;
        if (inflight_q.size() == 0) begin
            errors++;
            $display("retire requested with nothing in flight");
        end else begin
            f = inflight_q.pop_front();
            c_retire_i[slot] = 1'b1;
            c_wvalid_i[slot] = 1'b1;
            c_wcheck_i[slot] = f.check;
            c_arfid_i[slot] = f.rd;
            c_robid_i[slot] = f.robid;
            c_data_i[slot] = data;
        end
    endtask

    // predict, hand the bundle to the comparer and advance the model by one clock
    task automatic step();
        bit pred;
        bundle_t e;
        int n_iss;
        int n_ret;
        #1;
        for (int i = 0; i < 2; i++) begin
            if (c_retire_i[i] && c_wvalid_i[i] && c_arfid_i[i] != 0) begin
                commit_m[c_arfid_i[i]] = {c_wcheck_i[i], c_robid_i[i]};
                arf_m[c_arfid_i[i]] = c_data_i[i];
            end
        end
        pred = avail_m && !c_flush_i && p_ready_i;
        check_val("d_ready_o", 64'(d_ready_o), 64'(pred));
        e = expect_bundle(d_valid_i && pred);
        n_iss = 0;
        for (int i = 0; i < 2; i++) begin
            if (e.slot_valid[i]) begin
                n_iss++;
                if (d_wreg_i[i] && d_rd_id_i[i] != 0) begin
                    spec_m[d_rd_id_i[i]] = {e.dst_check[i], e.dst_robid[i]};
                end
            end
        end
        // ROB order is robid order
        if (e.slot_valid == 2'b10) begin
            inflight_q.push_back({e.dst_robid[1], e.dst_check[1], d_rd_id_i[1]});
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (e.slot_valid[i]) begin
                    inflight_q.push_back({e.dst_robid[i], e.dst_check[i], d_rd_id_i[i]});
                end
            end
        end
        exp_bundle = e;
        launch = d_valid_i && pred;
        n_ret = int'(c_retire_i[0]) + int'(c_retire_i[1]);
        if (c_flush_i) begin
            clear_model();
        end else begin
            occ_m = occ_m + n_iss - n_ret;
            ptr0_m = ptr0_m + rob_id_t'(n_iss);
            avail_m = (occ_m <= `RN_ROB_HIGH_WATER);
        end
        @(negedge clk);
        idle_inputs();
    endtask

    // retire everything in flight at two per cycle
    task automatic drain();
        int n;
        n = 0;
        while (inflight_q.size() > 0 && n < 100) begin
            drive_retire(0, $urandom);
            if (inflight_q.size() > 0) begin
                drive_retire(1, $urandom);
            end
            step();
            n++;
        end
        if (inflight_q.size() > 0) begin
            note_timeout("the in-flight queue to drain");
        end
    endtask

    task automatic begin_test();
        start_errs = errors;
        start_touts = timeouts;
        tests++;
    endtask

    task automatic end_test(input string name);
        if (errors == start_errs && timeouts == start_touts) begin
            $display("test %0d %s: ok", tests, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED", tests, name);
        end
    endtask

    // compares one cycle after each accept
    always begin
        @(posedge clk);
        if (launch) begin
            cmp_exp = exp_bundle;
            @(negedge clk);
            compare_bundle(cmp_exp);
        end
    end

    initial begin
        void'($urandom(32'hc425));
        idle_inputs();
        launch = 1'b0;
        checks = 0;
        errors = 0;
        timeouts = 0;
        tests = 0;
        tests_failed = 0;
        clear_model();
        for (int i = 0; i < `RN_ARF_DEPTH; i++) begin
            arf_m[i] = '0;
        end

        k = 0;
        @(negedge clk);
        while (rst_i && k < 40) begin
            @(negedge clk);
            k++;
        end
        if (rst_i) begin
            note_timeout("reset release");
        end

        begin_test();
        check_val("d_ready_o after reset", 64'(d_ready_o), 64'(1'b1));
        drive_bundle(2'b11, random_rs(), {5'd2, 5'd1});
        step();
        step();
        end_test("reset state");

        begin_test();
        drive_bundle(2'b11, random_rs(), {5'd4, 5'd3});
        step();
        drive_bundle(2'b11, {5'd4, 5'd3, 5'd2, 5'd1}, {5'd9, 5'd8});
        step();
        drive_bundle(2'b10, {5'd9, 5'd4, 5'd0, 5'd3}, {5'd7, 5'd6});
        step();
        drive_bundle(2'b01, {5'd7, 5'd6, 5'd8, 5'd7}, {5'd10, 5'd3});
        step();
        step();
        end_test("dual and single slot dispatch");

        begin_test();
        drain();
        drive_bundle(2'b01, random_rs(), {5'd0, 5'd5});
        step();
        drive_retire(0, 32'h1234_5678);
        drive_bundle(2'b11, {5'd5, 5'd0, 5'd5, 5'd1}, {5'd0, 5'd0});
        step();
        drive_retire(0, 32'hdead_beef);
        drive_retire(1, 32'hcafe_f00d);
        step();
        drive_bundle(2'b11, {5'd0, 5'd5, 5'd0, 5'd5}, {5'd12, 5'd0});
        step();
        step();
        end_test("retire into ARF");

        begin_test();
        k = 0;
        while (d_ready_o && k < 80) begin
            drive_bundle(2'b11, random_rs(), {5'($urandom_range(0, 31)), 5'd13});
            step();
            k++;
        end
        if (d_ready_o) begin
            note_timeout("d_ready_o to fall");
        end
        check_val("occupancy over high water", 64'(occ_m > `RN_ROB_HIGH_WATER), 64'(1'b1));
        k = 0;
        while (!d_ready_o && k < 40) begin
            drive_retire(0, $urandom);
            drive_retire(1, $urandom);
            step();
            k++;
        end
        if (!d_ready_o) begin
            note_timeout("d_ready_o to rise");
        end
        drain();
        end_test("high water stall");

        begin_test();
        drive_bundle(2'b11, random_rs(), {5'd14, 5'd15});
        step();
        held = {p_slot_valid_o, p_src_robid_o, p_src_data_o, p_src_ready_o,
                p_dst_robid_o, p_dst_check_o, p_pc_o};
        for (int i = 0; i < 4; i++) begin
            drive_bundle(2'b11, random_rs(), {5'd16, 5'd17});
            p_ready_i = 1'b0;
            step();
            compare_bundle(held);
        end
        drive_bundle(2'b11, random_rs(), {5'd16, 5'd17});
        step();
        step();
        end_test("dispatch backpressure");

        begin_test();
        drive_bundle(2'b11, random_rs(), {5'd20, 5'd21});
        step();
        drive_retire(0, 32'h0bad_cafe);
        step();
        drive_bundle(2'b11, random_rs(), {5'd22, 5'd23});
        c_flush_i = 1'b1;
        step();
        drive_bundle(2'b11, {5'd20, 5'd21, 5'd5, 5'd15}, {5'd24, 5'd25});
        step();
        drive_bundle(2'b11, random_rs(), 10'(random_rs()));
        step();
        step();
        end_test("flush");

        $display("checks: %0d, errors: %0d, timeouts: %0d, tests failed: %0d of %0d",
                 checks, errors, timeouts, tests_failed, tests);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dv/rename_chk.sv
`timescale 1ns/1ns
`default_nettype none

module rename_chk (
    input wire logic        clk,
    input wire logic        rst_i,
    input wire logic        flush_i,
    input wire logic        p_ready_i,
    input wire logic        d_ready_i,
    input wire logic [1:0]  slot_valid_i,
    input wire logic [3:0]  src_ready_i,
    input wire logic [31:0] pc_i
);

    // decode is stopped during a flush
    a_flush_stalls: assert property (@(posedge clk) flush_i |-> !d_ready_i)
        else $error("d_ready_o high during flush");

    // outputs hold while dispatch is not ready
    a_hold: assert property (@(posedge clk) disable iff (rst_i)
        (!p_ready_i && !flush_i) |=> ($stable(slot_valid_i) && $stable(src_ready_i)
                                      && $stable(pc_i)))
        else $error("outputs changed while p_ready_i low");

    a_reset_clear: assert property (@(posedge clk) rst_i |=> (slot_valid_i == 2'b00))
        else $error("p_slot_valid_o set after reset");

endmodule

`default_nettype wire

// File: dv/tb_clkgen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;
    end

    // reset held for ten rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

// File: hdl/rename_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module rename_stage (
    input  logic                          clk,
    input  logic                          rst_i,

    // from decode
    input  logic                          d_valid_i,
    input  logic [1:0]                    d_slot_valid_i,
    input  rename_pkg::arf_id_t [3:0]     d_rs_id_i,
    input  rename_pkg::arf_id_t [1:0]     d_rd_id_i,
    input  logic [1:0]                    d_wreg_i,
    input  rename_pkg::xlen_t             d_pc_i,
    output logic                          d_ready_o,

    // to dispatch
    output logic [1:0]                    p_slot_valid_o,
    output rename_pkg::rob_id_t [3:0]     p_src_robid_o,
    output rename_pkg::xlen_t [3:0]       p_src_data_o,
    output logic [3:0]                    p_src_ready_o,
    output rename_pkg::rob_id_t [1:0]     p_dst_robid_o,
    output logic [1:0]                    p_dst_check_o,
    output rename_pkg::xlen_t             p_pc_o,
    input  logic                          p_ready_i,

    // from commit
    input  logic                          c_flush_i,
    input  logic [1:0]                    c_retire_i,
    input  logic [1:0]                    c_wvalid_i,
    input  logic [1:0]                    c_wcheck_i,
    input  rename_pkg::arf_id_t [1:0]     c_arfid_i,
    input  rename_pkg::rob_id_t [1:0]     c_robid_i,
    input  rename_pkg::xlen_t [1:0]       c_data_i
);

    import rename_pkg::*;

    logic              rob_avail;
    rob_id_t           alloc_ptr0;
    rob_id_t           alloc_ptr1;
    logic              accept;
    logic [1:0]        issue;
    rob_id_t [1:0]     dst_robid;
    logic [1:0]        dst_check;
    logic [1:0]        spec_we;
    rat_entry_t [1:0]  spec_wdata;
    rat_entry_t [3:0]  spec_src;
    arf_id_t [5:0]     commit_raddr;
    rat_entry_t [5:0]  commit_rdata;
    logic [1:0]        commit_we;
    rat_entry_t [1:0]  commit_wdata;
    xlen_t [3:0]       arf_rdata;
    logic [3:0]        src_ready;
    xlen_t [3:0]       src_data;

    assign d_ready_o = rob_avail & ~c_flush_i & p_ready_i;
    assign accept    = d_valid_i & d_ready_o;
    assign issue     = d_slot_valid_i & {2{accept}};

    rob_alloc u_rob_alloc (
        .clk      (clk),
        .rst_i    (rst_i),
        .flush_i  (c_flush_i),
        .issue_i  (issue),
        .retire_i (c_retire_i),
        .ptr0_o   (alloc_ptr0),
        .ptr1_o   (alloc_ptr1),
        .avail_o  (rob_avail)
    );

    // a lone slot 1 takes the first free robid
    always_comb begin
        if (!issue[0] && issue[1]) begin
            dst_robid[0] = alloc_ptr1;
            dst_robid[1] = alloc_ptr0;
        end else begin
            dst_robid[0] = alloc_ptr0;
            dst_robid[1] = alloc_ptr1;
        end
    end

    // sources in 0..3, destinations of both slots in 4..5
    assign commit_raddr = {d_rd_id_i, d_rs_id_i};

    for (genvar i = 0; i < 2; i++) begin : g_dst
        assign dst_check[i]        = ~commit_rdata[4+i].check;
        assign spec_we[i]          = issue[i] & d_wreg_i[i] & (d_rd_id_i[i] != '0);
        assign spec_wdata[i].check = dst_check[i];
        assign spec_wdata[i].robid = dst_robid[i];

        assign commit_we[i]          = c_retire_i[i] & c_wvalid_i[i] & (c_arfid_i[i] != '0);
        assign commit_wdata[i].check = c_wcheck_i[i];
        assign commit_wdata[i].robid = c_robid_i[i];
    end

    reg_table #(
        .ENTRY_T (rat_entry_t),
        .DEPTH   (`RN_ARF_DEPTH),
        .R_PORTS (4),
        .FORWARD (1'b0)
    ) spec_rat (
        .clk     (clk),
        .rst_i   (rst_i),
        .clr_i   (c_flush_i),
        .raddr_i (d_rs_id_i),
        .rdata_o (spec_src),
        .we_i    (spec_we),
        .waddr_i (d_rd_id_i),
        .wdata_i (spec_wdata)
    );

    reg_table #(
        .ENTRY_T (rat_entry_t),
        .DEPTH   (`RN_ARF_DEPTH),
        .R_PORTS (6),
        .FORWARD (1'b1)
    ) commit_rat (
        .clk     (clk),
        .rst_i   (rst_i),
        .clr_i   (c_flush_i),
        .raddr_i (commit_raddr),
        .rdata_o (commit_rdata),
        .we_i    (commit_we),
        .waddr_i (c_arfid_i),
        .wdata_i (commit_wdata)
    );

    // flush leaves the architectural values in place
    reg_table #(
        .ENTRY_T (xlen_t),
        .DEPTH   (`RN_ARF_DEPTH),
        .R_PORTS (4),
        .FORWARD (1'b1)
    ) arf (
        .clk     (clk),
        .rst_i   (rst_i),
        .clr_i   (1'b0),
        .raddr_i (d_rs_id_i),
        .rdata_o (arf_rdata),
        .we_i    (commit_we),
        .waddr_i (c_arfid_i),
        .wdata_i (c_data_i)
    );

    // latest value is architectural once both tables agree
    for (genvar j = 0; j < 4; j++) begin : g_src
        assign src_ready[j] = (d_rs_id_i[j] == '0) | (spec_src[j] == commit_rdata[j]);
        assign src_data[j]  = (d_rs_id_i[j] == '0) ? '0 : arf_rdata[j];
    end

    always_ff @(posedge clk) begin
        if (rst_i || c_flush_i) begin
            p_slot_valid_o <= '0;
        end else if (p_ready_i) begin
            // zero unless this edge accepts a bundle
            p_slot_valid_o <= issue;
        end
    end

    // bundle payload
    always_ff @(posedge clk) begin
        if (p_ready_i) begin
            for (int j = 0; j < 4; j++) begin
                p_src_robid_o[j] <= spec_src[j].robid;
            end
            p_src_data_o  <= src_data;
            p_src_ready_o <= src_ready;
            p_dst_robid_o <= dst_robid;
            p_dst_check_o <= dst_check;
            p_pc_o        <= d_pc_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rob_alloc.sv
`timescale 1ns/1ns
`default_nettype none

`include "rename_config.svh"

module rob_alloc (
    input  logic               clk,
    input  logic               rst_i,
    input  logic               flush_i,
    input  logic [1:0]         issue_i,
    input  logic [1:0]         retire_i,
    output rename_pkg::rob_id_t ptr0_o,
    output rename_pkg::rob_id_t ptr1_o,
    output logic               avail_o
);

    import rename_pkg::*;

    // one bit wider than a robid, occupancy can reach the full ROB
    typedef logic [`RN_ROB_W:0] occ_t;

    occ_t       occ_q;
    occ_t       occ_next;
    logic [1:0] n_issue;
    rob_id_t    ptr0_q;
    rob_id_t    ptr1_q;
    logic       avail_q;

    assign n_issue = {1'b0, issue_i[0]} + {1'b0, issue_i[1]};

    always_comb begin
        occ_next = occ_q + occ_t'(n_issue) - occ_t'(retire_i[0]) - occ_t'(retire_i[1]);
    end

    always_ff @(posedge clk) begin
        if (rst_i || flush_i) begin
            occ_q   <= '0;
            ptr0_q  <= '0;
            ptr1_q  <= rob_id_t'(1);
            avail_q <= 1'b1;
        end else begin
            occ_q   <= occ_next;
            // pointers wrap naturally at the ROB size
            ptr0_q  <= ptr0_q + rob_id_t'(n_issue);
            ptr1_q  <= ptr1_q + rob_id_t'(n_issue);
            // registered, tracks the occupancy held in occ_q
            avail_q <= (occ_next <= occ_t'(`RN_ROB_HIGH_WATER));
        end
    end

    assign ptr0_o  = ptr0_q;
    assign ptr1_o  = ptr1_q;
    assign avail_o = avail_q;

endmodule

`default_nettype wire

// File: hdl/reg_table.sv
`timescale 1ns/1ns
`default_nettype none

module reg_table #(
    parameter type         ENTRY_T = logic [31:0],
    parameter int unsigned DEPTH   = 32,
    parameter int unsigned R_PORTS = 4,
    parameter bit          FORWARD = 1'b0,
    localparam int unsigned AW     = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  logic                         clk,
    input  logic                         rst_i,
    input  logic                         clr_i,
    input  logic [R_PORTS-1:0][AW-1:0]   raddr_i,
    output ENTRY_T [R_PORTS-1:0]         rdata_o,
    input  logic [1:0]                   we_i,
    input  logic [1:0][AW-1:0]           waddr_i,
    input  ENTRY_T [1:0]                 wdata_i
);

    ENTRY_T mem [DEPTH];

    // port 1 is written last, so it wins on an address clash
    always_ff @(posedge clk) begin
        if (rst_i || clr_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (we_i[0]) begin
                mem[waddr_i[0]] <= wdata_i[0];
            end
            if (we_i[1]) begin
                mem[waddr_i[1]] <= wdata_i[1];
            end
        end
    end

    // combinational reads
    always_comb begin
        for (int r = 0; r < R_PORTS; r++) begin
            rdata_o[r] = mem[raddr_i[r]];
            if (FORWARD) begin
                // same order as the write, port 1 last
                if (we_i[0] && (waddr_i[0] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[0];
                end
                if (we_i[1] && (waddr_i[1] == raddr_i[r])) begin
                    rdata_o[r] = wdata_i[1];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/rename_pkg.sv
`default_nettype none

`include "rename_config.svh"

package rename_pkg;

    // architectural register number
    typedef logic [`RN_ARF_W-1:0] arf_id_t;

    // physical name of a destination, one per ROB entry
    typedef logic [`RN_ROB_W-1:0] rob_id_t;

    // one alias table entry
    // check flips on every rename of a register, so a stale robid that wrapped
    // around can never match the committed entry by accident
    typedef struct packed {
        logic    check;
        rob_id_t robid;
    } rat_entry_t;

    // data word of the ARF and the bundle
    typedef logic [`RN_XLEN-1:0] xlen_t;

endpackage

`default_nettype wire

// File: hdl/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural register file
`define RN_ARF_DEPTH 32
`define RN_ARF_W 5

// reorder buffer ids
`define RN_ROB_W 6

// decode may enter while occupancy is at or below this
`define RN_ROB_HIGH_WATER 60

// data path width
`define RN_XLEN 32

`endif
